// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module mipsTb -f sources.f
out=$(./obj_dir/VmipsTb)
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***'

// ==== source/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [mipsPkg::dataWidth-1:0]    fInstr,
    input  logic [mipsPkg::dataWidth-1:0]    fPc,
    input  logic [mipsPkg::regAddrWidth-1:0] eDst,
    input  logic [mipsPkg::dataWidth-1:0]    eFwdData,
    input  mipsPkg::tnewT                    eTnew,
    input  logic [mipsPkg::regAddrWidth-1:0] mDst,
    input  logic [mipsPkg::dataWidth-1:0]    mFwdData,
    input  mipsPkg::tnewT                    mTnew,
    input  logic [mipsPkg::regAddrWidth-1:0] wDst,
    input  logic [mipsPkg::dataWidth-1:0]    wData,
    output logic                             stall,
    output logic                             branchTaken,
    output logic [mipsPkg::dataWidth-1:0]    branchTarget,
    output mipsPkg::opcodeT                  dOp,
    output logic [mipsPkg::dataWidth-1:0]    dPc,
    output logic [mipsPkg::regAddrWidth-1:0] dRsAddr,
    output logic [mipsPkg::regAddrWidth-1:0] dRtAddr,
    output logic [mipsPkg::regAddrWidth-1:0] dDst,
    output logic [mipsPkg::dataWidth-1:0]    dRsData,
    output logic [mipsPkg::dataWidth-1:0]    dRtData,
    output logic [mipsPkg::dataWidth-1:0]    dImm
);

    logic [mipsPkg::dataWidth-1:0] rf [2**mipsPkg::regAddrWidth];
    logic [mipsPkg::opWidth-1:0]   opRaw;
    logic [mipsPkg::opWidth-1:0]   funct;
    logic [mipsPkg::immWidth-1:0]  imm;
    mipsPkg::tnewT                 tuseRs;
    mipsPkg::tnewT                 tuseRt;
    logic                          rsStall;
    logic                          rtStall;

    assign opRaw   = fInstr[mipsPkg::opField +: mipsPkg::opWidth];
    assign funct   = fInstr[mipsPkg::functField +: mipsPkg::opWidth];
    assign imm     = fInstr[mipsPkg::immField +: mipsPkg::immWidth];
    assign dRsAddr = fInstr[mipsPkg::rsField +: mipsPkg::regAddrWidth];
    assign dRtAddr = fInstr[mipsPkg::rtField +: mipsPkg::regAddrWidth];
    assign dPc     = fPc;

    always_comb begin
        case (opRaw)
            mipsPkg::opcodeRtype: begin
                dOp = (funct == mipsPkg::functAddu) ? mipsPkg::opAddu :
                      (funct == mipsPkg::functSubu) ? mipsPkg::opSubu : mipsPkg::opNop;
            end
            mipsPkg::opcodeOri: dOp = mipsPkg::opOri;
            mipsPkg::opcodeLui: dOp = mipsPkg::opLui;
            mipsPkg::opcodeLw:  dOp = mipsPkg::opLw;
            mipsPkg::opcodeSw:  dOp = mipsPkg::opSw;
            mipsPkg::opcodeBeq: dOp = mipsPkg::opBeq;
            default:            dOp = mipsPkg::opNop; // unknown word
        endcase
    end

    always_comb begin
        case (dOp)
            mipsPkg::opAddu, mipsPkg::opSubu: begin
                dDst = fInstr[mipsPkg::rdField +: mipsPkg::regAddrWidth];
            end
            mipsPkg::opOri, mipsPkg::opLui, mipsPkg::opLw: dDst = dRtAddr;
            default: dDst = '0; // sw, beq, nop write nothing
        endcase
        case (dOp)
            mipsPkg::opOri: dImm = {16'b0, imm};
            mipsPkg::opLui: dImm = {imm, 16'b0};
            default:        dImm = {{16{imm[15]}}, imm};
        endcase
    end

    ////////////////////
    // register file, written from writeback
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**mipsPkg::regAddrWidth; i++) begin
                rf[i] <= '0;
            end
        end else if (wDst != '0) begin
            rf[wDst] <= wData;
        end
    end

    // newest producer wins
    function automatic logic [mipsPkg::dataWidth-1:0] fwdValue(
        input logic [mipsPkg::regAddrWidth-1:0] addr
    );
        if (addr == '0) return '0;
        if (addr == eDst) return eFwdData;
        if (addr == mDst) return mFwdData;
        if (addr == wDst) return wData; // write before read
        return rf[addr];
    endfunction

    always_comb begin
        dRsData = fwdValue(dRsAddr);
        dRtData = fwdValue(dRtAddr);
    end

    ////////////////////
    // Tuse per source, 3 means never read
    always_comb begin
        tuseRs = 2'd3;
        tuseRt = 2'd3;
        case (dOp)
            mipsPkg::opBeq: begin
                tuseRs = 2'd0;
                tuseRt = 2'd0;
            end
            mipsPkg::opAddu, mipsPkg::opSubu: begin
                tuseRs = 2'd1;
                tuseRt = 2'd1;
            end
            mipsPkg::opOri, mipsPkg::opLw: tuseRs = 2'd1;
            mipsPkg::opSw: begin
                tuseRs = 2'd1; // address in execute
                tuseRt = 2'd2; // store data in memory
            end
            default: ;
        endcase
    end

    assign rsStall = (dRsAddr != '0) &&
                     ((dRsAddr == eDst && tuseRs < eTnew) || (dRsAddr == mDst && tuseRs < mTnew));
    assign rtStall = (dRtAddr != '0) &&
                     ((dRtAddr == eDst && tuseRt < eTnew) || (dRtAddr == mDst && tuseRt < mTnew));
    assign stall   = rsStall || rtStall;

    assign branchTaken  = (dOp == mipsPkg::opBeq) && (dRsData == dRtData) && !stall;
    assign branchTarget = fPc + 32'd4 + {dImm[29:0], 2'b00}; // from delay slot pc

endmodule

`default_nettype wire

// ==== source/executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             stall,
    input  mipsPkg::opcodeT                  dOp,
    input  logic [mipsPkg::dataWidth-1:0]    dPc,
    input  logic [mipsPkg::regAddrWidth-1:0] dRsAddr,
    input  logic [mipsPkg::regAddrWidth-1:0] dRtAddr,
    input  logic [mipsPkg::regAddrWidth-1:0] dDst,
    input  logic [mipsPkg::dataWidth-1:0]    dRsData,
    input  logic [mipsPkg::dataWidth-1:0]    dRtData,
    input  logic [mipsPkg::dataWidth-1:0]    dImm,
    input  logic [mipsPkg::regAddrWidth-1:0] mDst,
    input  logic [mipsPkg::dataWidth-1:0]    mFwdData,
    input  logic [mipsPkg::regAddrWidth-1:0] wDst,
    input  logic [mipsPkg::dataWidth-1:0]    wData,
    output mipsPkg::opcodeT                  eOp,
    output logic [mipsPkg::dataWidth-1:0]    ePc,
    output logic [mipsPkg::regAddrWidth-1:0] eDst,
    output logic [mipsPkg::regAddrWidth-1:0] eRtAddr,
    output logic [mipsPkg::dataWidth-1:0]    eAluOut,
    output logic [mipsPkg::dataWidth-1:0]    eRtData,
    output logic [mipsPkg::dataWidth-1:0]    eImm,
    output logic [mipsPkg::dataWidth-1:0]    eFwdData,
    output mipsPkg::tnewT                    eTnew
);

    logic [mipsPkg::regAddrWidth-1:0] rsAddr;
    logic [mipsPkg::dataWidth-1:0]    rsData;
    logic [mipsPkg::dataWidth-1:0]    rtData;
    logic [mipsPkg::dataWidth-1:0]    rsFwd;
    logic [mipsPkg::dataWidth-1:0]    aluB;
    mipsPkg::aluOpT                   aluOp;

    always_ff @(posedge clk) begin
        if (rst || stall) begin
            eOp  <= mipsPkg::opNop; // bubble
            eDst <= '0;
        end else begin
            eOp  <= dOp;
            eDst <= dDst;
        end
    end

    always_ff @(posedge clk) begin
        ePc     <= dPc;
        rsAddr  <= dRsAddr;
        eRtAddr <= dRtAddr;
        rsData  <= dRsData;
        rtData  <= dRtData;
        eImm    <= dImm;
    end

    function automatic logic [mipsPkg::dataWidth-1:0] fwdValue(
        input logic [mipsPkg::regAddrWidth-1:0] addr,
        input logic [mipsPkg::dataWidth-1:0]    held
    );
        if (addr == '0) return '0;
        if (addr == mDst) return mFwdData;
        if (addr == wDst) return wData;
        return held;
    endfunction

    ////////////////////
    // ALU
    always_comb begin
        rsFwd   = fwdValue(rsAddr, rsData);
        eRtData = fwdValue(eRtAddr, rtData); // also the store data
        case (eOp)
            mipsPkg::opSubu: aluOp = mipsPkg::aluSub;
            mipsPkg::opOri:  aluOp = mipsPkg::aluOr;
            default:         aluOp = mipsPkg::aluAdd;
        endcase
        aluB = (eOp == mipsPkg::opOri || eOp == mipsPkg::opLw || eOp == mipsPkg::opSw) ?
               eImm : eRtData;
        case (aluOp)
            mipsPkg::aluSub: eAluOut = rsFwd - aluB;
            mipsPkg::aluOr:  eAluOut = rsFwd | aluB;
            default:         eAluOut = rsFwd + aluB;
        endcase
    end

    assign eFwdData = eImm; // only lui is ready here

    always_comb begin
        case (mipsPkg::resultSrcOf(eOp))
            mipsPkg::resMem: eTnew = 2'd2;
            mipsPkg::resAlu: eTnew = 2'd1;
            default:         eTnew = 2'd0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/fetchStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              progWe,
    input  logic [mipsPkg::imemAddrWidth-1:0] progAddr,
    input  logic [mipsPkg::dataWidth-1:0]     progData,
    input  logic                              stall,
    input  logic                              branchTaken,
    input  logic [mipsPkg::dataWidth-1:0]     branchTarget,
    output logic [mipsPkg::dataWidth-1:0]     fInstr,
    output logic [mipsPkg::dataWidth-1:0]     fPc
);

    logic [mipsPkg::dataWidth-1:0] imem [mipsPkg::imemDepth];
    logic [mipsPkg::dataWidth-1:0] pc;
    logic [mipsPkg::dataWidth-1:0] pcNext;
    logic [mipsPkg::dataWidth-1:0] instr;

    assign pcNext = branchTaken ? branchTarget : pc + 32'd4;
    assign instr  = imem[pc[mipsPkg::imemAddrWidth+1:2]]; // word addressed

    always_ff @(posedge clk) begin
        if (rst && progWe) begin
            imem[progAddr] <= progData; // program load only in reset
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= '0;
            fInstr <= '0; // all-zero word decodes as nop
            fPc    <= '0;
        end else if (!stall) begin
            pc     <= pcNext;
            fInstr <= instr;
            fPc    <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== source/memoryStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memoryStage (
    input  logic                             clk,
    input  logic                             rst,
    input  mipsPkg::opcodeT                  eOp,
    input  logic [mipsPkg::dataWidth-1:0]    ePc,
    input  logic [mipsPkg::regAddrWidth-1:0] eDst,
    input  logic [mipsPkg::regAddrWidth-1:0] eRtAddr,
    input  logic [mipsPkg::dataWidth-1:0]    eAluOut,
    input  logic [mipsPkg::dataWidth-1:0]    eRtData,
    input  logic [mipsPkg::dataWidth-1:0]    eImm,
    input  logic [mipsPkg::regAddrWidth-1:0] wDst,
    input  logic [mipsPkg::dataWidth-1:0]    wData,
    output mipsPkg::opcodeT                  mOp,
    output logic [mipsPkg::dataWidth-1:0]    mPc,
    output logic [mipsPkg::regAddrWidth-1:0] mDst,
    output logic [mipsPkg::dataWidth-1:0]    mAluOut,
    output logic [mipsPkg::dataWidth-1:0]    mImm,
    output logic [mipsPkg::dataWidth-1:0]    mMemData,
    output logic [mipsPkg::dataWidth-1:0]    mFwdData,
    output mipsPkg::tnewT                    mTnew,
    output logic                             storeValid,
    output logic [mipsPkg::dataWidth-1:0]    storeAddr,
    output logic [mipsPkg::dataWidth-1:0]    storeData
);

    logic [mipsPkg::dataWidth-1:0]     dmem [mipsPkg::dmemDepth];
    logic [mipsPkg::regAddrWidth-1:0]  rtAddr;
    logic [mipsPkg::dataWidth-1:0]     rtData;
    logic [mipsPkg::dmemAddrWidth-1:0] wordAddr;

    always_ff @(posedge clk) begin
        if (rst) begin
            mOp  <= mipsPkg::opNop;
            mDst <= '0;
        end else begin
            mOp  <= eOp;
            mDst <= eDst;
        end
    end

    always_ff @(posedge clk) begin
        mPc     <= ePc;
        rtAddr  <= eRtAddr;
        mAluOut <= eAluOut;
        rtData  <= eRtData;
        mImm    <= eImm;
    end

    // load just reaching writeback feeds a following sw
    assign storeData = (rtAddr == '0) ? '0 :
                       (rtAddr == wDst) ? wData : rtData;

    assign storeValid = (mOp == mipsPkg::opSw);
    assign storeAddr  = mAluOut;
    assign wordAddr   = mAluOut[mipsPkg::dmemAddrWidth+1:2];

    ////////////////////
    // data memory
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < mipsPkg::dmemDepth; i++) begin
                dmem[i] <= '0;
            end
        end else if (storeValid) begin
            dmem[wordAddr] <= storeData;
        end
    end

    assign mMemData = dmem[wordAddr];

    assign mFwdData = (mipsPkg::resultSrcOf(mOp) == mipsPkg::resImm) ? mImm : mAluOut;
    assign mTnew    = (mOp == mipsPkg::opLw) ? 2'd1 : 2'd0;

endmodule

`default_nettype wire

// ==== source/mipsCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              progWe,
    input  logic [mipsPkg::imemAddrWidth-1:0] progAddr,
    input  logic [mipsPkg::dataWidth-1:0]     progData,
    output logic                              wbValid,
    output logic [mipsPkg::regAddrWidth-1:0]  wbReg,
    output logic [mipsPkg::dataWidth-1:0]     wbData,
    output logic [mipsPkg::dataWidth-1:0]     wbPc,
    output logic                              storeValid,
    output logic [mipsPkg::dataWidth-1:0]     storeAddr,
    output logic [mipsPkg::dataWidth-1:0]     storeData
);

    logic [mipsPkg::dataWidth-1:0]    fInstr, fPc, branchTarget;
    logic                             stall, branchTaken;
    mipsPkg::opcodeT                  dOp, eOp, mOp;
    logic [mipsPkg::dataWidth-1:0]    dPc, dRsData, dRtData, dImm;
    logic [mipsPkg::regAddrWidth-1:0] dRsAddr, dRtAddr, dDst;
    logic [mipsPkg::dataWidth-1:0]    ePc, eAluOut, eRtData, eImm, eFwdData;
    logic [mipsPkg::regAddrWidth-1:0] eDst, eRtAddr, mDst, wDst;
    mipsPkg::tnewT                    eTnew, mTnew;
    logic [mipsPkg::dataWidth-1:0]    mPc, mAluOut, mImm, mMemData, mFwdData, wData;

    ////////////////////
    fetchStage fetchStage_inst (
        .clk          (clk),
        .rst          (rst),
        .progWe       (progWe),
        .progAddr     (progAddr),
        .progData     (progData),
        .stall        (stall),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .fInstr       (fInstr),
        .fPc          (fPc)
    );

    decodeStage decodeStage_inst (
        .clk          (clk),
        .rst          (rst),
        .fInstr       (fInstr),
        .fPc          (fPc),
        .eDst         (eDst),
        .eFwdData     (eFwdData),
        .eTnew        (eTnew),
        .mDst         (mDst),
        .mFwdData     (mFwdData),
        .mTnew        (mTnew),
        .wDst         (wDst),
        .wData        (wData),
        .stall        (stall),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .dOp          (dOp),
        .dPc          (dPc),
        .dRsAddr      (dRsAddr),
        .dRtAddr      (dRtAddr),
        .dDst         (dDst),
        .dRsData      (dRsData),
        .dRtData      (dRtData),
        .dImm         (dImm)
    );

    ////////////////////
    executeStage executeStage_inst (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .dOp      (dOp),
        .dPc      (dPc),
        .dRsAddr  (dRsAddr),
        .dRtAddr  (dRtAddr),
        .dDst     (dDst),
        .dRsData  (dRsData),
        .dRtData  (dRtData),
        .dImm     (dImm),
        .mDst     (mDst),
        .mFwdData (mFwdData),
        .wDst     (wDst),
        .wData    (wData),
        .eOp      (eOp),
        .ePc      (ePc),
        .eDst     (eDst),
        .eRtAddr  (eRtAddr),
        .eAluOut  (eAluOut),
        .eRtData  (eRtData),
        .eImm     (eImm),
        .eFwdData (eFwdData),
        .eTnew    (eTnew)
    );

    memoryStage memoryStage_inst (
        .clk        (clk),
        .rst        (rst),
        .eOp        (eOp),
        .ePc        (ePc),
        .eDst       (eDst),
        .eRtAddr    (eRtAddr),
        .eAluOut    (eAluOut),
        .eRtData    (eRtData),
        .eImm       (eImm),
        .wDst       (wDst),
        .wData      (wData),
        .mOp        (mOp),
        .mPc        (mPc),
        .mDst       (mDst),
        .mAluOut    (mAluOut),
        .mImm       (mImm),
        .mMemData   (mMemData),
        .mFwdData   (mFwdData),
        .mTnew      (mTnew),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeData  (storeData)
    );

    writebackStage writebackStage_inst (
        .clk      (clk),
        .rst      (rst),
        .mOp      (mOp),
        .mPc      (mPc),
        .mDst     (mDst),
        .mAluOut  (mAluOut),
        .mImm     (mImm),
        .mMemData (mMemData),
        .wDst     (wDst),
        .wData    (wData),
        .wbValid  (wbValid),
        .wbReg    (wbReg),
        .wbData   (wbData),
        .wbPc     (wbPc)
    );

endmodule

`default_nettype wire

// ==== source/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

    ////////////////////
    // widths and depths
    localparam int dataWidth     = 32;
    localparam int regAddrWidth  = 5;
    localparam int imemDepth     = 256;
    localparam int imemAddrWidth = 8;
    localparam int dmemDepth     = 64;
    localparam int dmemAddrWidth = 6;

    ////////////////////
    // instruction fields, lsb positions
    localparam int opWidth    = 6;   // op and funct
    localparam int immWidth   = 16;
    localparam int opField    = 26;
    localparam int rsField    = 21;
    localparam int rtField    = 16;
    localparam int rdField    = 11;
    localparam int functField = 0;
    localparam int immField   = 0;

    // raw encodings
    localparam logic [opWidth-1:0] opcodeRtype = 6'h00;
    localparam logic [opWidth-1:0] opcodeBeq   = 6'h04;
    localparam logic [opWidth-1:0] opcodeOri   = 6'h0d;
    localparam logic [opWidth-1:0] opcodeLui   = 6'h0f;
    localparam logic [opWidth-1:0] opcodeLw    = 6'h23;
    localparam logic [opWidth-1:0] opcodeSw    = 6'h2b;
    localparam logic [opWidth-1:0] functAddu   = 6'h21;
    localparam logic [opWidth-1:0] functSubu   = 6'h23;

    ////////////////////
    typedef enum logic [2:0] {
        opNop,
        opAddu,
        opSubu,
        opOri,
        opLui,
        opLw,
        opSw,
        opBeq
    } opcodeT;

    typedef enum logic [1:0] {
        aluAdd,
        aluSub,
        aluOr
    } aluOpT;

    typedef enum logic [1:0] {
        resAlu,
        resMem,
        resImm
    } resultSrcT;

    typedef logic [1:0] tnewT; // cycles until result exists

    // which value a stage writes back or forwards
    function automatic resultSrcT resultSrcOf(input opcodeT op);
        case (op)
            opLw:    return resMem;
            opLui:   return resImm;
            default: return resAlu;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== source/writebackStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module writebackStage (
    input  logic                             clk,
    input  logic                             rst,
    input  mipsPkg::opcodeT                  mOp,
    input  logic [mipsPkg::dataWidth-1:0]    mPc,
    input  logic [mipsPkg::regAddrWidth-1:0] mDst,
    input  logic [mipsPkg::dataWidth-1:0]    mAluOut,
    input  logic [mipsPkg::dataWidth-1:0]    mImm,
    input  logic [mipsPkg::dataWidth-1:0]    mMemData,
    output logic [mipsPkg::regAddrWidth-1:0] wDst,
    output logic [mipsPkg::dataWidth-1:0]    wData,
    output logic                             wbValid,
    output logic [mipsPkg::regAddrWidth-1:0] wbReg,
    output logic [mipsPkg::dataWidth-1:0]    wbData,
    output logic [mipsPkg::dataWidth-1:0]    wbPc
);

    mipsPkg::opcodeT               wOp;
    logic [mipsPkg::dataWidth-1:0] aluOut;
    logic [mipsPkg::dataWidth-1:0] imm;
    logic [mipsPkg::dataWidth-1:0] memData;

    always_ff @(posedge clk) begin
        if (rst) begin
            wOp  <= mipsPkg::opNop;
            wDst <= '0;
        end else begin
            wOp  <= mOp;
            wDst <= mDst;
        end
    end

    always_ff @(posedge clk) begin
        wbPc    <= mPc;
        aluOut  <= mAluOut;
        imm     <= mImm;
        memData <= mMemData;
    end

    always_comb begin
        case (mipsPkg::resultSrcOf(wOp))
            mipsPkg::resMem: wData = memData;
            mipsPkg::resImm: wData = imm;
            default:         wData = aluOut;
        endcase
    end

    assign wbValid = (wDst != '0); // r0 never reported
    assign wbReg   = wDst;
    assign wbData  = wData;

endmodule

`default_nettype wire

// ==== sources.f ====
source/mipsPkg.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/writebackStage.sv
source/mipsCore.sv
verif/clockGen.sv
verif/mipsTb.sv

// ==== verif/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

endmodule

`default_nettype wire

// ==== verif/mipsTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsTb;

    localparam int numGen     = 120;            // generated instructions
    localparam int progLen    = numGen + 2;     // plus the end loop and its delay slot
    localparam int resetHold  = 8;
    localparam int cycleLimit = progLen + resetHold + 3 * numGen + 50;

    logic                              clk;
    logic                              rst;
    logic                              progWe;
    logic [mipsPkg::imemAddrWidth-1:0] progAddr;
    logic [mipsPkg::dataWidth-1:0]     progData;
    logic                              wbValid;
    logic [mipsPkg::regAddrWidth-1:0]  wbReg;
    logic [mipsPkg::dataWidth-1:0]     wbData;
    logic [mipsPkg::dataWidth-1:0]     wbPc;
    logic                              storeValid;
    logic [mipsPkg::dataWidth-1:0]     storeAddr;
    logic [mipsPkg::dataWidth-1:0]     storeData;

    integer      seed;
    logic [31:0] prog [progLen];
    logic [31:0] modelRegs [32];
    logic [4:0]  expWbReg [$];
    logic [31:0] expWbData [$];
    logic [31:0] expWbPc [$];
    string       expWbName [$];
    logic [31:0] expStAddr [$];
    logic [31:0] expStData [$];
    int          wbIdx;
    int          stIdx;
    int          wbErrors;
    int          storeErrors;
    int          miscErrors;
    int          cycleCount;
    logic        timedOut;

    clockGen clockGen_inst (
        .clk (clk)
    );

    mipsCore mipsCore_inst (
        .clk        (clk),
        .rst        (rst),
        .progWe     (progWe),
        .progAddr   (progAddr),
        .progData   (progData),
        .wbValid    (wbValid),
        .wbReg      (wbReg),
        .wbData     (wbData),
        .wbPc       (wbPc),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeData  (storeData)
    );

    function automatic int randBelow(input int limit);
        return int'($unsigned($random(seed)) % limit);
    endfunction

    function automatic logic [31:0] rtypeWord(input logic [5:0] funct, input int rs,
                                              input int rt, input int rd);
        logic [31:0] w;
        w = '0;
        w[mipsPkg::opField +: mipsPkg::opWidth]      = mipsPkg::opcodeRtype;
        w[mipsPkg::rsField +: mipsPkg::regAddrWidth] = 5'(rs);
        w[mipsPkg::rtField +: mipsPkg::regAddrWidth] = 5'(rt);
        w[mipsPkg::rdField +: mipsPkg::regAddrWidth] = 5'(rd);
        w[mipsPkg::functField +: mipsPkg::opWidth]   = funct;
        return w;
    endfunction

    function automatic logic [31:0] itypeWord(input logic [5:0] op, input int rs,
                                              input int rt, input logic [15:0] imm);
        logic [31:0] w;
        w = '0;
        w[mipsPkg::opField +: mipsPkg::opWidth]      = op;
        w[mipsPkg::rsField +: mipsPkg::regAddrWidth] = 5'(rs);
        w[mipsPkg::rtField +: mipsPkg::regAddrWidth] = 5'(rt);
        w[mipsPkg::immField +: mipsPkg::immWidth]    = imm;
        return w;
    endfunction

    ////////////////////
    // random program on r0..r7
    task automatic buildProgram();
        int   kind;
        int   rs;
        int   rt;
        int   rd;
        int   maxOff;
        logic prevBeq;
        prevBeq = 1'b0;
        for (int i = 0; i < numGen; i++) begin
            kind = randBelow(8);
            rs   = randBelow(8);
            rt   = randBelow(8);
            rd   = randBelow(8);
            if (kind == 7 && (prevBeq || i == numGen - 1)) begin
                kind = 0; // a beq never sits in a delay slot
            end
            case (kind)
                0, 6: prog[7'(i)] = rtypeWord(mipsPkg::functAddu, rs, rt, rd);
                1:    prog[7'(i)] = rtypeWord(mipsPkg::functSubu, rs, rt, rd);
                2:    prog[7'(i)] = itypeWord(mipsPkg::opcodeOri, rs, rt, 16'(randBelow(256)));
                3:    prog[7'(i)] = itypeWord(mipsPkg::opcodeLui, 0, rt, 16'(randBelow(65536)));
                4:    prog[7'(i)] = itypeWord(mipsPkg::opcodeLw, 0, rt, 16'(randBelow(16) * 4));
                5:    prog[7'(i)] = itypeWord(mipsPkg::opcodeSw, 0, rt, 16'(randBelow(16) * 4));
                default: begin
                    if (randBelow(3) == 0) begin
                        rt = rs; // always taken
                    end
                    maxOff = (numGen - 1 - i < 4) ? numGen - 1 - i : 4;
                    prog[7'(i)] = itypeWord(mipsPkg::opcodeBeq, rs, rt,
                                            16'(1 + randBelow(maxOff)));
                end
            endcase
            prevBeq = (kind == 7);
        end
        prog[7'(numGen)]     = itypeWord(mipsPkg::opcodeBeq, 0, 0, 16'hffff); // loops on itself
        prog[7'(numGen + 1)] = 32'h0000_0000; // nop delay slot
    endtask

    task automatic logWrite(input logic [4:0] dst, input logic [31:0] value,
                            input logic [31:0] pc, input string name);
        if (dst != '0) begin
            modelRegs[dst] = value;
            expWbReg.push_back(dst);
            expWbData.push_back(value);
            expWbPc.push_back(pc);
            expWbName.push_back(name);
        end
    endtask

    ////////////////////
    // instruction-level model with one delay slot
    task automatic runModel();
        logic [31:0] mem [mipsPkg::dmemDepth];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] nextNpc;
        logic [31:0] w;
        logic [31:0] simm;
        logic [31:0] addr;
        logic [5:0]  opc;
        logic [5:0]  fn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            modelRegs[5'(i)] = '0;
        end
        for (int i = 0; i < mipsPkg::dmemDepth; i++) begin
            mem[6'(i)] = '0;
        end
        pc    = '0;
        npc   = 32'd4;
        steps = 0;
        while (pc != 32'(numGen * 4) && steps < 2 * progLen) begin
            w       = prog[pc[8:2]];
            opc     = w[mipsPkg::opField +: mipsPkg::opWidth];
            fn      = w[mipsPkg::functField +: mipsPkg::opWidth];
            rs      = w[mipsPkg::rsField +: mipsPkg::regAddrWidth];
            rt      = w[mipsPkg::rtField +: mipsPkg::regAddrWidth];
            rd      = w[mipsPkg::rdField +: mipsPkg::regAddrWidth];
            simm    = {{16{w[15]}}, w[15:0]};
            nextNpc = npc + 32'd4;
            case (opc)
                mipsPkg::opcodeRtype: begin
                    if (fn == mipsPkg::functAddu) begin
                        logWrite(rd, modelRegs[rs] + modelRegs[rt], pc, "aluForward");
                    end else if (fn == mipsPkg::functSubu) begin
                        logWrite(rd, modelRegs[rs] - modelRegs[rt], pc, "aluForward");
                    end
                end
                mipsPkg::opcodeOri: begin
                    logWrite(rt, modelRegs[rs] | {16'b0, w[15:0]}, pc, "aluForward");
                end
                mipsPkg::opcodeLui: logWrite(rt, {w[15:0], 16'b0}, pc, "aluForward");
                mipsPkg::opcodeLw: begin
                    addr = modelRegs[rs] + simm;
                    logWrite(rt, mem[addr[7:2]], pc, "loadUse");
                end
                mipsPkg::opcodeSw: begin
                    addr = modelRegs[rs] + simm;
                    mem[addr[7:2]] = modelRegs[rt];
                    expStAddr.push_back(addr);
                    expStData.push_back(modelRegs[rt]);
                end
                mipsPkg::opcodeBeq: begin
                    if (modelRegs[rs] == modelRegs[rt]) begin
                        nextNpc = pc + 32'd4 + {simm[29:0], 2'b00};
                    end
                end
                default: ;
            endcase
            pc  = npc;
            npc = nextNpc;
            steps++;
        end
    endtask

    ////////////////////
    // compare observation ports with the model
    task automatic writebackCheck();
        assert (wbIdx < expWbReg.size()) else begin
            $display("writeback: unexpected write r%0d=%h at pc %h", wbReg, wbData, wbPc);
            wbErrors++;
        end
        assert (wbReg != '0) else begin
            $display("writeback: a write to register zero was reported");
            wbErrors++;
        end
        if (wbIdx < expWbReg.size()) begin
            assert (wbReg == expWbReg[wbIdx] && wbData == expWbData[wbIdx]) else begin
                $display("FAILED %s: expected r%0d=%h, actual r%0d=%h", expWbName[wbIdx],
                         expWbReg[wbIdx], expWbData[wbIdx], wbReg, wbData);
                wbErrors++;
            end
            assert (wbPc == expWbPc[wbIdx]) else begin
                $display("FAILED branchPc: expected pc %h, actual pc %h", expWbPc[wbIdx], wbPc);
                wbErrors++;
            end
        end
        wbIdx++;
    endtask

    task automatic storeCheck();
        assert (stIdx < expStAddr.size()) else begin
            $display("store: unexpected store of %h to %h", storeData, storeAddr);
            storeErrors++;
        end
        if (stIdx < expStAddr.size()) begin
            assert (storeAddr == expStAddr[stIdx] && storeData == expStData[stIdx]) else begin
                $display("FAILED storeLoad: expected [%h]=%h, actual [%h]=%h",
                         expStAddr[stIdx], expStData[stIdx], storeAddr, storeData);
                storeErrors++;
            end
        end
        stIdx++;
    endtask

    // outputs settle after the rising edge, so look at them on the falling one
    initial begin
        @(posedge clk);
        forever begin
            @(negedge clk);
            cycleCount = cycleCount + 1;
            if (rst) begin
                assert (!wbValid && !storeValid) else begin
                    $display("reset: a writeback or store strobe went high in reset");
                    miscErrors++;
                end
            end else begin
                if (wbValid) writebackCheck();
                if (storeValid) storeCheck();
            end
            if (cycleCount >= cycleLimit &&
                (wbIdx < expWbReg.size() || stIdx < expStAddr.size())) begin
                timedOut = 1'b1;
            end
        end
    end

    initial begin
        rst         = 1'b1;
        progWe      = 1'b0;
        progAddr    = '0;
        progData    = '0;
        seed        = 81;
        wbIdx       = 0;
        stIdx       = 0;
        wbErrors    = 0;
        storeErrors = 0;
        miscErrors  = 0;
        cycleCount  = 0;
        timedOut    = 1'b0;
        buildProgram();
        runModel();
        $display("program of %0d words, expecting %0d writes and %0d stores",
                 progLen, expWbReg.size(), expStAddr.size());

        for (int i = 0; i < progLen; i++) begin
            @(posedge clk);
            progWe   <= 1'b1;
            progAddr <= 8'(i);
            progData <= prog[7'(i)];
        end
        @(posedge clk);
        progWe <= 1'b0;
        repeat (resetHold) @(posedge clk);
        rst <= 1'b0;

        while (!timedOut && (wbIdx < expWbReg.size() || stIdx < expStAddr.size())) begin
            @(posedge clk);
        end
        if (timedOut) begin
            $display("timeout after %0d cycles: %0d of %0d writes and %0d of %0d stores seen",
                     cycleCount, wbIdx, expWbReg.size(), stIdx, expStAddr.size());
            miscErrors++;
        end else begin
            repeat (10) @(posedge clk); // extra writes would show up here
            assert (wbIdx == expWbReg.size() && stIdx == expStAddr.size()) else begin
                $display("count of writes or stores differs from the model");
                miscErrors++;
            end
        end

        $display("errors: writeback %0d, store %0d, other %0d",
                 wbErrors, storeErrors, miscErrors);
        if (wbErrors + storeErrors + miscErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
